// File: hdl/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Width of one pixel or coefficient word
`define BIT_LENGTH 8

// Multiply-accumulate lanes, one per kernel column
`define LANE_COUNT 3

// Rows walked per run
`define NUM_LOOP 3

// Input FIFO entries
`define FIFO_DEPTH 16

// Lane sums and the final result
`define ACC_LENGTH 20

`endif

// File: hdl/convDataPkg.sv
`include "conv_macros.svh"

package convDataPkg;

    // Pixel and coefficient words are signed
    typedef logic signed [`BIT_LENGTH-1:0] dataWord;

    // Full-precision product of two data words
    typedef logic signed [2*`BIT_LENGTH-1:0] productWord;

    // Lane sums and the reduced result
    typedef logic signed [`ACC_LENGTH-1:0] accWord;

    // Selects one of the lanes
    typedef logic [$clog2(`LANE_COUNT)-1:0] laneIndex;

endpackage

// File: hdl/convCtrlPkg.sv
package convCtrlPkg;

    // Controller phases
    typedef enum logic [2:0] {
        PhIdle,
        PhRead,
        PhMultiply,
        PhAdd,
        PhReady
    } convPhase;

    // Operation the controller requests from the lanes
    typedef enum logic [1:0] {
        OpNone,
        OpClear,
        OpMac
    } laneOp;

endpackage

// File: hdl/sampleFifo.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module sampleFifo (
    input  logic                 Clk,
    input  logic                 Rst,
    input  logic                 wrEn,
    input  convDataPkg::dataWord wrData,
    input  logic                 rdEn,
    output convDataPkg::dataWord rdData,
    output logic                 full,
    output logic                 empty
);
    import convDataPkg::*;

    localparam int AddrWidth = $clog2(`FIFO_DEPTH);
    localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(`FIFO_DEPTH - 1);
    localparam logic [AddrWidth:0] DepthCount = (AddrWidth + 1)'(`FIFO_DEPTH);

    dataWord mem [`FIFO_DEPTH];

    logic [AddrWidth-1:0] wrPtr;
    logic [AddrWidth-1:0] rdPtr;
    logic [AddrWidth:0]   count;
    logic                 doWrite;
    logic                 doRead;

    assign full  = (count == DepthCount);
    assign empty = (count == '0);

    // Writes while full and reads while empty are dropped
    assign doWrite = wrEn && !full;
    assign doRead  = rdEn && !empty;

    // Head word falls through to the output
    assign rdData = mem[rdPtr];

    always_ff @(posedge Clk) begin
        if (doWrite) begin
            mem[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == LastAddr) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == LastAddr) ? '0 : rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy stays within the buffer
    assert property (@(posedge Clk) disable iff (Rst) count <= DepthCount);

endmodule

// File: hdl/convController.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module convController (
    input  logic                  Clk,
    input  logic                  Rst,
    input  logic                  start,
    input  logic                  keepKernel,
    output logic                  fifoRd,
    input  logic                  fifoEmpty,
    input  convDataPkg::dataWord  fifoData,
    output logic                  loadPixel,
    output logic                  loadCoef,
    output convDataPkg::laneIndex laneSel,
    output convDataPkg::dataWord  operand,
    output convCtrlPkg::laneOp    laneOp,
    output logic                  addEn,
    output convDataPkg::laneIndex addSel,
    output logic                  ready
);
    import convDataPkg::*;
    import convCtrlPkg::*;

    localparam int RowWidth = $clog2(`NUM_LOOP);
    localparam laneIndex LastLane = laneIndex'(`LANE_COUNT - 1);
    localparam logic [RowWidth-1:0] LastRow = RowWidth'(`NUM_LOOP - 1);

    convPhase            phase;
    logic                keepReg;
    logic                toggle;
    laneIndex            lanePtr;
    logic [RowWidth-1:0] rowCnt;
    logic                pairDone;

    // FIFO head is consumed on the edge where fifoRd is high
    assign fifoRd = (phase == PhRead) && !fifoEmpty;

    // Even reads are pixels, odd reads coefficients
    assign loadPixel = fifoRd && !toggle;
    assign loadCoef  = fifoRd && toggle;

    // With a held kernel the pixel alone completes the pair
    assign pairDone = fifoRd && (toggle || keepReg);

    assign laneSel = lanePtr;
    assign operand = fifoData;

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            phase   <= PhIdle;
            keepReg <= 1'b0;
            toggle  <= 1'b0;
            lanePtr <= '0;
            rowCnt  <= '0;
            laneOp  <= OpNone;
            addEn   <= 1'b0;
            addSel  <= '0;
            ready   <= 1'b0;
        end else begin
            case (phase)
                PhIdle, PhReady: begin
                    // A start is only taken when not busy
                    if (start) begin
                        phase   <= PhRead;
                        keepReg <= keepKernel;
                        toggle  <= 1'b0;
                        lanePtr <= '0;
                        rowCnt  <= '0;
                        laneOp  <= OpClear;
                        ready   <= 1'b0;
                    end
                end
                PhRead: begin
                    laneOp <= OpNone;
                    if (fifoRd && !keepReg) begin
                        toggle <= ~toggle;
                    end
                    if (pairDone) begin
                        laneOp <= OpMac;
                        phase  <= PhMultiply;
                    end
                end
                PhMultiply: begin
                    // laneSel still points at the lane being multiplied
                    laneOp <= OpNone;
                    if (lanePtr == LastLane) begin
                        lanePtr <= '0;
                        if (rowCnt == LastRow) begin
                            phase <= PhAdd;
                        end else begin
                            rowCnt <= rowCnt + 1'b1;
                            phase  <= PhRead;
                        end
                    end else begin
                        lanePtr <= lanePtr + 1'b1;
                        phase   <= PhRead;
                    end
                end
                PhAdd: begin
                    // First cycle lets the last lane sum settle
                    if (addEn && addSel == LastLane) begin
                        addEn  <= 1'b0;
                        addSel <= '0;
                        ready  <= 1'b1;
                        phase  <= PhReady;
                    end else begin
                        addEn <= 1'b1;
                        if (addEn) begin
                            addSel <= addSel + 1'b1;
                        end
                    end
                end
                default: phase <= PhIdle;
            endcase
        end
    end

    assert property (@(posedge Clk) disable iff (Rst) fifoRd |-> !fifoEmpty);

    assert property (@(posedge Clk) disable iff (Rst) !(loadPixel && loadCoef));

endmodule

// File: hdl/macLanes.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module macLanes (
    input  logic                  Clk,
    input  logic                  Rst,
    input  logic                  loadPixel,
    input  logic                  loadCoef,
    input  convDataPkg::laneIndex laneSel,
    input  convDataPkg::dataWord  operand,
    input  convCtrlPkg::laneOp    laneOp,
    output convDataPkg::accWord   laneSums [`LANE_COUNT]
);
    import convDataPkg::*;
    import convCtrlPkg::*;

    dataWord    pixelReg [`LANE_COUNT];
    dataWord    coefReg  [`LANE_COUNT];
    productWord products [`LANE_COUNT];

    // Coefficients stay put between runs for the held-kernel mode
    always_ff @(posedge Clk) begin
        if (loadPixel) begin
            pixelReg[laneSel] <= operand;
        end
        if (loadCoef) begin
            coefReg[laneSel] <= operand;
        end
    end

    always_comb begin
        for (int i = 0; i < `LANE_COUNT; i++) begin
            products[i] = pixelReg[i] * coefReg[i];
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            for (int i = 0; i < `LANE_COUNT; i++) begin
                laneSums[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `LANE_COUNT; i++) begin
                if (laneOp == OpClear) begin
                    laneSums[i] <= '0;
                end else if (laneOp == OpMac && laneSel == laneIndex'(i)) begin
                    // Product is sign extended into the accumulator
                    laneSums[i] <= laneSums[i] + accWord'(products[i]);
                end
            end
        end
    end

    // Multiply only targets an existing lane
    assert property (@(posedge Clk) disable iff (Rst)
        (laneOp == OpMac) |-> (laneSel < laneIndex'(`LANE_COUNT)));

    // Operands are never reloaded during their own multiply
    assert property (@(posedge Clk) disable iff (Rst)
        (laneOp == OpMac) |-> !(loadPixel || loadCoef));

endmodule

// File: hdl/sumReducer.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module sumReducer (
    input  logic                  Clk,
    input  logic                  Rst,
    input  logic                  clear,
    input  logic                  addEn,
    input  convDataPkg::laneIndex addSel,
    input  convDataPkg::accWord   laneSums [`LANE_COUNT],
    output convDataPkg::accWord   result
);
    import convDataPkg::*;

    accWord selSum;

    assign selSum = laneSums[addSel];

    // Total holds once the add steps are done
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            result <= '0;
        end else if (clear) begin
            result <= '0;
        end else if (addEn) begin
            result <= result + selSum;
        end
    end

    // Clear comes at run start, adds only at the end
    assert property (@(posedge Clk) disable iff (Rst) !(clear && addEn));

    // A selected sum always comes from a real lane
    assert property (@(posedge Clk) disable iff (Rst)
        addEn |-> (addSel < laneIndex'(`LANE_COUNT)));

endmodule

// File: hdl/convEngine.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module convEngine (
    input  logic                 Clk,
    input  logic                 Rst,
    input  logic                 wrEn,
    input  convDataPkg::dataWord wrData,
    output logic                 full,
    input  logic                 start,
    input  logic                 keepKernel,
    output logic                 ready,
    output convDataPkg::accWord  result
);
    import convDataPkg::*;
    import convCtrlPkg::*;

    // FIFO to controller
    dataWord  fifoData;
    logic     fifoRd;
    logic     fifoEmpty;

    // Controller to lanes
    logic     loadPixel;
    logic     loadCoef;
    laneIndex laneSel;
    dataWord  operand;
    laneOp    laneOpSig;

    // Lanes and controller to reducer
    accWord   laneSums [`LANE_COUNT];
    logic     addEn;
    laneIndex addSel;
    logic     reducerClear;

    // Reducer restarts on the same cycle the lanes clear
    assign reducerClear = (laneOpSig == OpClear);

    sampleFifo u_fifo (
        .Clk    (Clk),
        .Rst    (Rst),
        .wrEn   (wrEn),
        .wrData (wrData),
        .rdEn   (fifoRd),
        .rdData (fifoData),
        .full   (full),
        .empty  (fifoEmpty)
    );

    convController u_ctrl (
        .Clk        (Clk),
        .Rst        (Rst),
        .start      (start),
        .keepKernel (keepKernel),
        .fifoRd     (fifoRd),
        .fifoEmpty  (fifoEmpty),
        .fifoData   (fifoData),
        .loadPixel  (loadPixel),
        .loadCoef   (loadCoef),
        .laneSel    (laneSel),
        .operand    (operand),
        .laneOp     (laneOpSig),
        .addEn      (addEn),
        .addSel     (addSel),
        .ready      (ready)
    );

    macLanes u_lanes (
        .Clk       (Clk),
        .Rst       (Rst),
        .loadPixel (loadPixel),
        .loadCoef  (loadCoef),
        .laneSel   (laneSel),
        .operand   (operand),
        .laneOp    (laneOpSig),
        .laneSums  (laneSums)
    );

    sumReducer u_reducer (
        .Clk      (Clk),
        .Rst      (Rst),
        .clear    (reducerClear),
        .addEn    (addEn),
        .addSel   (addSel),
        .laneSums (laneSums),
        .result   (result)
    );

endmodule

// File: verification/tbConvEngine.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module tbConvEngine;
    import convDataPkg::*;

    localparam int RstCycles     = 8;
    localparam int NumTests      = 6;
    localparam int CyclesPerTest = 200;
    localparam int ReadyTimeout  = 150;
    localparam int PairCount     = `NUM_LOOP * `LANE_COUNT;

    logic    Clk = 1'b0;
    logic    Rst;
    logic    wrEn;
    dataWord wrData;
    logic    full;
    logic    start;
    logic    keepKernel;
    logic    ready;
    accWord  result;

    // Words written by a test, and the words its run is expected to consume
    dataWord stim[$];
    dataWord modelWords[$];
    // Last coefficient loaded into each lane
    dataWord modelCoef [`LANE_COUNT];

    logic [31:0] lcgState = 32'd94336;
    int          testErrors = 0;
    int          passCount = 0;
    int          failCount = 0;
    accWord      expected;

    convEngine u_dut (
        .Clk        (Clk),
        .Rst        (Rst),
        .wrEn       (wrEn),
        .wrData     (wrData),
        .full       (full),
        .start      (start),
        .keepKernel (keepKernel),
        .ready      (ready),
        .result     (result)
    );

    always #10 Clk = ~Clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Appends random words; consumed words also go to the model
    function automatic void addWords(input int n, input logic consumed);
        dataWord w;
        for (int i = 0; i < n; i++) begin
            w = dataWord'(nextRand() >> 24);
            stim.push_back(w);
            if (consumed) begin
                modelWords.push_back(w);
            end
        end
    endfunction

    // Pairs arrive row by row, lane by lane; a held kernel sends pixels only
    function automatic accWord modelSum(input logic keep);
        int sum;
        int idx;
        int lane;
        sum = 0;
        idx = 0;
        for (int pair = 0; pair < PairCount; pair++) begin
            lane = pair % `LANE_COUNT;
            if (!keep) begin
                modelCoef[lane] = modelWords[idx + 1];
            end
            sum += int'(modelWords[idx]) * int'(modelCoef[lane]);
            idx += keep ? 1 : 2;
        end
        return accWord'(sum);
    endfunction

    task automatic newRun();
        stim.delete();
        modelWords.delete();
    endtask

    task automatic writeStim(input int maxGap);
        int gap;
        foreach (stim[i]) begin
            @(posedge Clk);
            wrEn   <= 1'b1;
            wrData <= stim[i];
            gap = int'(nextRand() >> 28) % (maxGap + 1);
            repeat (gap) begin
                @(posedge Clk);
                wrEn <= 1'b0;
            end
        end
        @(posedge Clk);
        wrEn <= 1'b0;
    endtask

    task automatic pulseStart(input logic keep);
        @(posedge Clk);
        start      <= 1'b1;
        keepKernel <= keep;
        @(posedge Clk);
        start <= 1'b0;
    endtask

    // The FIFO takes its depth of words before the run starts draining it
    task automatic preloadRun(input logic keep);
        dataWord rest[$];
        while (stim.size() > `FIFO_DEPTH) begin
            rest.push_front(stim.pop_back());
        end
        writeStim(0);
        pulseStart(keep);
        stim = rest;
        writeStim(0);
    endtask

    task automatic waitReady(input string name);
        int cycles;
        cycles = 0;
        @(negedge Clk);
        while (!ready && cycles < ReadyTimeout) begin
            @(negedge Clk);
            cycles++;
        end
        assert (ready) else begin
            $display("%s: ready did not rise within %0d cycles", name, ReadyTimeout);
            testErrors++;
        end
    endtask

    task automatic checkResult(input string name, input accWord exp);
        assert (result == exp) else begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, result);
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        if (testErrors == 0) begin
            $display("PASS %s", name);
            passCount++;
        end else begin
            $display("FAIL %s with %0d errors", name, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    // Result holds while ready stays high
    assert property (@(posedge Clk) disable iff (Rst) (ready && $past(ready)) |-> $stable(result))
        else begin
            $display("Result changed while ready was held high");
            testErrors++;
        end

    // ready only drops on an accepted start
    assert property (@(posedge Clk) disable iff (Rst) $fell(ready) |-> $past(start))
        else begin
            $display("ready fell without a start pulse");
            testErrors++;
        end

    initial begin
        repeat (RstCycles + NumTests * CyclesPerTest) @(posedge Clk);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        Rst        = 1'b1;
        wrEn       = 1'b0;
        wrData     = '0;
        start      = 1'b0;
        keepKernel = 1'b0;
        repeat (RstCycles) @(posedge Clk);
        Rst <= 1'b0;

        // Start on an empty FIFO waits for the data
        @(negedge Clk);
        assert (!ready && !full) else begin
            $display("emptyStart: ready or full set after reset");
            testErrors++;
        end
        pulseStart(1'b0);
        repeat (10) begin
            @(negedge Clk);
            assert (!ready) else begin
                $display("emptyStart: ready rose before any data arrived");
                testErrors++;
            end
        end
        newRun();
        addWords(2 * PairCount, 1'b1);
        expected = modelSum(1'b0);
        writeStim(0);
        waitReady("emptyStart");
        checkResult("emptyStart", expected);
        endTest("emptyStart");

        newRun();
        addWords(2 * PairCount, 1'b1);
        expected = modelSum(1'b0);
        preloadRun(1'b0);
        waitReady("prefilledRun");
        checkResult("prefilledRun", expected);
        endTest("prefilledRun");

        newRun();
        addWords(PairCount, 1'b1);
        expected = modelSum(1'b1);
        writeStim(0);
        pulseStart(1'b1);
        waitReady("keepKernel");
        checkResult("keepKernel", expected);
        endTest("keepKernel");

        // Gapped writes keep the read phase starved
        newRun();
        addWords(2 * PairCount, 1'b1);
        expected = modelSum(1'b0);
        pulseStart(1'b0);
        writeStim(3);
        waitReady("starvedRead");
        checkResult("starvedRead", expected);
        endTest("starvedRead");

        newRun();
        addWords(2 * PairCount, 1'b1);
        expected = modelSum(1'b0);
        preloadRun(1'b0);
        repeat (3) @(posedge Clk);
        pulseStart(1'b0);
        waitReady("busyStart");
        checkResult("busyStart", expected);
        newRun();
        addWords(PairCount, 1'b1);
        expected = modelSum(1'b1);
        writeStim(0);
        pulseStart(1'b1);
        @(negedge Clk);
        assert (!ready) else begin
            $display("busyStart: ready stayed high after a new start");
            testErrors++;
        end
        waitReady("busyStart");
        checkResult("busyStart", expected);
        endTest("busyStart");

        // The word written while full must not reach the run
        newRun();
        addWords(`FIFO_DEPTH, 1'b1);
        addWords(1, 1'b0);
        writeStim(0);
        @(negedge Clk);
        assert (full) else begin
            $display("fullFifo: full did not rise after sixteen writes");
            testErrors++;
        end
        stim.delete();
        addWords(2 * PairCount - `FIFO_DEPTH, 1'b1);
        expected = modelSum(1'b0);
        pulseStart(1'b0);
        writeStim(0);
        waitReady("fullFifo");
        checkResult("fullFifo", expected);
        endTest("fullFifo");

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/convDataPkg.sv
hdl/convCtrlPkg.sv
hdl/sampleFifo.sv
hdl/convController.sv
hdl/macLanes.sv
hdl/sumReducer.sv
hdl/convEngine.sv
verification/tbConvEngine.sv

// File: Makefile
# Verilator flow for the convolution engine
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tbConvEngine
RTL_TOP   ?= convEngine
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# The run passes only when the log holds the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
